/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := frontend_tb
FILELIST := filelist.f
RUNFLAGS := +verilator+error+limit+100

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

/* dv/frontend_sva.sv */
// Bound checker with concurrent assertions on the front end top-level ports
`timescale 1ns/1ps

module frontend_sva (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          ibuffer_valid_o,
  input logic                          ibuffer_ready_i,
  input fe_pkg::fetch_group_t          ibuffer_group_o,
  input logic                          flush_i,
  input logic                          miss_req_valid_o,
  input logic                          miss_req_ready_i,
  input logic [fe_pkg::PLEN-1:0]       miss_req_paddr_o,
  input logic [fe_pkg::IC_INDEX_W-1:0] miss_req_index_o,
  input logic                          refill_ready_o
);

  int fail_count = 0;

  // Outputs stay quiet in reset and on the release edge
  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |-> !ibuffer_valid_o && !miss_req_valid_o && !refill_ready_o)
    else begin
      fail_count++;
      $error("front end output active during reset");
    end

  // Line address is 16-byte aligned and the index is bits [7:4]
  a_miss_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_req_valid_o |-> (miss_req_paddr_o[3:0] == 4'h0) &&
                         (miss_req_index_o == miss_req_paddr_o[7:4]))
    else begin
      fail_count++;
      $error("miss request paddr %h misaligned or index %h wrong",
             miss_req_paddr_o, miss_req_index_o);
    end

  a_miss_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_paddr_o))
    else begin
      fail_count++;
      $error("miss request dropped or changed before ready");
    end

  // A stalled group holds until the backend takes it
  a_group_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibuffer_valid_o && !ibuffer_ready_i && !flush_i |=>
      ibuffer_valid_o && $stable(ibuffer_group_o))
    else begin
      fail_count++;
      $error("fetch group dropped or changed while stalled");
    end

endmodule

/* dv/frontend_tb.sv */
// Front end testbench with clock, reset, memory refill model, backend model and group checks
`timescale 1ns/1ps

module frontend_tb;
  import fe_pkg::*;

  localparam int              TIMEOUT_CYCLES = 4000;
  localparam logic [PLEN-1:0] MEM_KEY        = 32'hA5A5_0000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  ibuffer_valid;
  logic                  ibuffer_ready = 1'b0;
  fetch_group_t          ibuffer_group;
  logic                  flush;
  logic [PLEN-1:0]       redirect_pc;
  bpu_update_t           bpu_update;
  logic                  miss_req_valid;
  logic                  miss_req_ready;
  logic [PLEN-1:0]       miss_req_paddr;
  logic [IC_INDEX_W-1:0] miss_req_index;
  logic                  refill_valid;
  logic                  refill_ready;
  logic [PLEN-1:0]       refill_paddr;
  logic [LINE_BITS-1:0]  refill_data;

  int seed   = 81961;
  int cycles = 0;
  int errors = 0;
  int groups = 0;

  // Expected fetch stream
  logic [PLEN-1:0]    exp_fetch_pc = RESET_PC;
  logic [EPOCH_W-1:0] exp_epoch    = '0;
  logic               btb_trained  = 1'b0;
  logic [PLEN-1:0]    br_pc;
  logic [PLEN-1:0]    br_target;
  logic               miss_seen    = 1'b0;
  logic               prev_valid   = 1'b0;
  logic [PLEN-1:0]    prev_pc;

  always #5 clk = ~clk;

  frontend frontend_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .ibuffer_valid_o  (ibuffer_valid),
    .ibuffer_ready_i  (ibuffer_ready),
    .ibuffer_group_o  (ibuffer_group),
    .flush_i          (flush),
    .redirect_pc_i    (redirect_pc),
    .bpu_update_i     (bpu_update),
    .miss_req_valid_o (miss_req_valid),
    .miss_req_ready_i (miss_req_ready),
    .miss_req_paddr_o (miss_req_paddr),
    .miss_req_index_o (miss_req_index),
    .refill_valid_i   (refill_valid),
    .refill_ready_o   (refill_ready),
    .refill_paddr_i   (refill_paddr),
    .refill_data_i    (refill_data)
  );

  bind frontend frontend_sva sva_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ibuffer_valid_o  (ibuffer_valid_o),
    .ibuffer_ready_i  (ibuffer_ready_i),
    .ibuffer_group_o  (ibuffer_group_o),
    .flush_i          (flush_i),
    .miss_req_valid_o (miss_req_valid_o),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_req_paddr_o (miss_req_paddr_o),
    .miss_req_index_o (miss_req_index_o),
    .refill_ready_o   (refill_ready_o)
  );

  function automatic logic [ILEN-1:0] mem_word(input logic [PLEN-1:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  function automatic logic [LINE_BITS-1:0] mem_line(input logic [PLEN-1:0] addr);
    logic [LINE_BITS-1:0] line;
    for (int w = 0; w < LINE_BITS / ILEN; w++) begin
      line[w * ILEN +: ILEN] = mem_word(addr + PLEN'(4 * w));
    end
    return line;
  endfunction

  task automatic report_mismatch(input string what, input logic [PLEN-1:0] got,
                                 input logic [PLEN-1:0] want);
    errors++;
    $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
  endtask

  // ==========================================================
  // Group checks against the fetch rules
  // ==========================================================
  task automatic check_group(input fetch_group_t g);
    logic [PLEN-1:0]        base;
    logic [PLEN-1:0]        exp_npc;
    logic [FETCH_WIDTH-1:0] exp_valid;
    int                     entry;
    int                     hit_slot;
    base     = {exp_fetch_pc[PLEN-1:3], 3'b000};
    entry    = int'(exp_fetch_pc[2]);
    hit_slot = -1;
    // Lowest trained slot at or after the entry slot
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (hit_slot < 0 && s >= entry && btb_trained && base + PLEN'(4 * s) == br_pc) begin
        hit_slot = s;
      end
    end
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      exp_valid[s] = (s >= entry) && (hit_slot < 0 || s <= hit_slot);
      exp_npc      = (s == hit_slot) ? br_target : base + PLEN'(4 * (s + 1));
      assert (g.instr[s] == mem_word(base + PLEN'(4 * s)))
        else report_mismatch("instruction word", g.instr[s], mem_word(base + PLEN'(4 * s)));
      assert (g.pred_npc[s] == exp_npc)
        else report_mismatch("predicted next pc", g.pred_npc[s], exp_npc);
    end
    assert (g.pc == base) else report_mismatch("group pc", g.pc, base);
    assert (g.slot_valid == exp_valid)
      else report_mismatch("slot valid bits", PLEN'(g.slot_valid), PLEN'(exp_valid));
    assert (g.epoch == exp_epoch)
      else report_mismatch("epoch", PLEN'(g.epoch), PLEN'(exp_epoch));
    // Upper half of a line right after its lower half
    if (prev_valid && base[3] && prev_pc == base - PLEN'(8)) begin
      assert (!miss_seen) else begin
        errors++;
        $display("FAILED at %0t: new miss request for the line of %h", $time, base);
      end
    end
    prev_valid   = 1'b1;
    prev_pc      = base;
    exp_fetch_pc = (hit_slot >= 0) ? br_target : base + PLEN'(8);
  endtask

  // Backend side monitor
  // A flush kills any group offered in the same cycle
  always @(posedge clk) begin
    if (rst_n) begin
      if (flush) begin
        exp_fetch_pc = {redirect_pc[PLEN-1:2], 2'b00};
        exp_epoch    = exp_epoch + EPOCH_W'(1);
        prev_valid   = 1'b0;
      end else if (ibuffer_valid && ibuffer_ready) begin
        check_group(ibuffer_group);
        groups++;
        miss_seen = 1'b0;
      end
      if (miss_req_valid && miss_req_ready) begin
        miss_seen = 1'b1;
      end
      if (bpu_update.valid) begin
        btb_trained = 1'b1;
        br_pc       = bpu_update.pc;
        br_target   = bpu_update.target;
      end
    end
  end

  always @(posedge clk) begin
    ibuffer_ready <= rst_n && ($unsigned($random(seed)) % 4 != 0);
  end

  // ==========================================================
  // Memory refill model
  // ==========================================================
  initial begin : memory_model
    int              delay;
    logic [PLEN-1:0] addr;
    miss_req_ready = 1'b0;
    refill_valid   = 1'b0;
    refill_paddr   = '0;
    refill_data    = '0;
    forever begin
      @(posedge clk);
      if (rst_n && miss_req_valid) begin
        delay = 1 + int'($unsigned($random(seed)) % 4);
        addr  = miss_req_paddr;
        repeat (delay - 1) @(posedge clk);
        miss_req_ready <= 1'b1;
        @(posedge clk);
        miss_req_ready <= 1'b0;
        while (!refill_ready) begin
          @(posedge clk);
        end
        refill_valid <= 1'b1;
        refill_paddr <= addr;
        refill_data  <= mem_line(addr);
        @(posedge clk);
        refill_valid <= 1'b0;
      end
    end
  end

  task automatic wait_groups(input int n);
    int target;
    target = groups + n;
    while (groups < target) begin
      @(posedge clk);
    end
  endtask

  task automatic redirect(input logic [PLEN-1:0] pc);
    @(posedge clk);
    flush       <= 1'b1;
    redirect_pc <= pc;
    @(posedge clk);
    flush       <= 1'b0;
  endtask

  task automatic train_and_redirect(input logic [PLEN-1:0] br_addr,
                                    input logic [PLEN-1:0] br_dest,
                                    input logic [PLEN-1:0] restart_pc);
    @(posedge clk);
    bpu_update  <= '{valid: 1'b1, pc: br_addr, is_cond: 1'b1, taken: 1'b1, target: br_dest};
    flush       <= 1'b1;
    redirect_pc <= restart_pc;
    @(posedge clk);
    bpu_update  <= '0;
    flush       <= 1'b0;
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = frontend_i.sva_i.fail_count;
    $display("Checked %0d groups: %0d data errors, %0d assertion failures",
             groups, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: test phases not finished after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial begin
    rst_n       = 1'b0;
    flush       = 1'b0;
    redirect_pc = '0;
    bpu_update  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Sequential stream from the reset PC
    wait_groups(24);
    // Redirect into the upper slot of a group
    redirect(32'h0000_01C4);
    wait_groups(12);
    // Taken branch at 0x100 to 0x204, refetched from 0xF0
    train_and_redirect(32'h0000_0100, 32'h0000_0204, 32'h0000_00F0);
    wait_groups(16);
    // Second flush likely lands while the first miss is open
    redirect(32'h0000_0404);
    repeat (2) @(posedge clk);
    redirect(32'h0000_0600);
    wait_groups(12);
    finish_run();
  end

endmodule

/* filelist.f */
hw/fe_pkg.sv
hw/bpu.sv
hw/icache.sv
hw/ifu.sv
hw/frontend.sv
dv/frontend_sva.sv
dv/frontend_tb.sv

/* hw/bpu.sv */
// Direct-mapped branch target buffer with 2-bit counters, group lookup and training
`timescale 1ns/1ps

module bpu (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [fe_pkg::PLEN-1:0] lookup_pc_i,
  output fe_pkg::bpu_pred_t     pred_o,
  input  fe_pkg::bpu_update_t   update_i
);
  import fe_pkg::*;

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_ENTRIES-1:0] cond_q;
  logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
  logic [PLEN-1:0]        target_q [BTB_ENTRIES];
  logic [1:0]             ctr_q    [BTB_ENTRIES];

  logic [BTB_INDEX_W-1:0] upd_index;
  logic                   upd_hit;
  logic [1:0]             upd_ctr;

  // ==========================================================
  // Lookup over both slots of the group
  // ==========================================================
  always_comb begin
    logic [PLEN-1:0]        slot_pc;
    logic [BTB_INDEX_W-1:0] idx;
    logic                   taken;
    pred_o = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slot_pc = {lookup_pc_i[PLEN-1:3], 3'b000} + PLEN'(4 * s);
      idx     = slot_pc[2 +: BTB_INDEX_W];
      // Slots below the entry slot are never predicted
      taken   = (s >= int'(lookup_pc_i[2])) && valid_q[idx] &&
                (tag_q[idx] == slot_pc[PLEN-1 -: BTB_TAG_W]) &&
                (!cond_q[idx] || ctr_q[idx][1]);
      if (taken && !pred_o.hit) begin
        pred_o.hit    = 1'b1;
        pred_o.slot   = SLOT_W'(s);
        pred_o.target = target_q[idx];
      end
    end
  end

  // ==========================================================
  // Training
  // ==========================================================
  assign upd_index = update_i.pc[2 +: BTB_INDEX_W];
  assign upd_hit   = valid_q[upd_index] &&
                     (tag_q[upd_index] == update_i.pc[PLEN-1 -: BTB_TAG_W]);

  // New entries start weakly biased toward the outcome
  always_comb begin
    upd_ctr = update_i.taken ? 2'd2 : 2'd1;
    if (upd_hit) begin
      upd_ctr = ctr_q[upd_index];
      if (update_i.taken && ctr_q[upd_index] != 2'd3) begin
        upd_ctr = ctr_q[upd_index] + 2'd1;
      end else if (!update_i.taken && ctr_q[upd_index] != 2'd0) begin
        upd_ctr = ctr_q[upd_index] - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[upd_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      tag_q[upd_index]    <= update_i.pc[PLEN-1 -: BTB_TAG_W];
      target_q[upd_index] <= update_i.target;
      cond_q[upd_index]   <= update_i.is_cond;
      ctr_q[upd_index]    <= upd_ctr;
    end
  end

endmodule

/* hw/fe_pkg.sv */
// Front end widths, cache and predictor geometry, state enums and shared structs
package fe_pkg;

  // ==========================================================
  // Widths and geometry
  // ==========================================================
  localparam int PLEN        = 32;
  localparam int ILEN        = 32;
  localparam int FETCH_WIDTH = 2;
  localparam int SLOT_W      = $clog2(FETCH_WIDTH);
  localparam int GROUP_W     = FETCH_WIDTH * ILEN;

  localparam int LINE_BITS   = 128;
  localparam int IC_SETS     = 16;
  localparam int IC_INDEX_W  = 4;
  localparam int IC_OFFSET_W = $clog2(LINE_BITS / 8);
  localparam int IC_TAG_W    = PLEN - IC_INDEX_W - IC_OFFSET_W;

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_INDEX_W = $clog2(BTB_ENTRIES);
  // Entry index sits just above the word offset
  localparam int BTB_TAG_W   = PLEN - BTB_INDEX_W - 2;

  localparam int EPOCH_W     = 3;

  localparam logic [PLEN-1:0] RESET_PC = 32'h0000_0000;

  // ==========================================================
  // State encodings
  // ==========================================================
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_RSP,
    HOLD
  } fetch_state_e;

  typedef enum logic [1:0] {
    READY,
    MISS_REQ,
    REFILL
  } ic_state_e;

  // ==========================================================
  // Shared structs
  // ==========================================================
  // Resolved branch from the backend
  typedef struct packed {
    logic            valid;
    logic [PLEN-1:0] pc;
    logic            is_cond;
    logic            taken;
    logic [PLEN-1:0] target;
  } bpu_update_t;

  typedef struct packed {
    logic              hit;
    logic [SLOT_W-1:0] slot;
    logic [PLEN-1:0]   target;
  } bpu_pred_t;

  // Group handed to the instruction buffer
  typedef struct packed {
    logic [PLEN-1:0]                  pc;
    logic [FETCH_WIDTH-1:0][ILEN-1:0] instr;
    logic [FETCH_WIDTH-1:0]           slot_valid;
    logic [FETCH_WIDTH-1:0][PLEN-1:0] pred_npc;
    logic [EPOCH_W-1:0]               epoch;
  } fetch_group_t;

endpackage

/* hw/frontend.sv */
// Front end top with fetch unit, branch predictor and instruction cache
`timescale 1ns/1ps

module frontend (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  // Backend instruction buffer
  output logic                           ibuffer_valid_o,
  input  logic                           ibuffer_ready_i,
  output fe_pkg::fetch_group_t           ibuffer_group_o,

  // Flush, redirect and predictor training
  input  logic                           flush_i,
  input  logic [fe_pkg::PLEN-1:0]        redirect_pc_i,
  input  fe_pkg::bpu_update_t            bpu_update_i,

  // Memory miss and refill
  output logic                           miss_req_valid_o,
  input  logic                           miss_req_ready_i,
  output logic [fe_pkg::PLEN-1:0]        miss_req_paddr_o,
  output logic [fe_pkg::IC_INDEX_W-1:0]  miss_req_index_o,
  input  logic                           refill_valid_i,
  output logic                           refill_ready_o,
  input  logic [fe_pkg::PLEN-1:0]        refill_paddr_i,
  input  logic [fe_pkg::LINE_BITS-1:0]   refill_data_i
);
  import fe_pkg::*;

  logic [PLEN-1:0]                  lookup_pc;
  bpu_pred_t                        bpu_pred;
  logic                             ic_req_valid;
  logic [PLEN-1:0]                  ic_req_addr;
  logic                             ic_flush;
  logic                             ic_rsp_valid;
  logic [FETCH_WIDTH-1:0][ILEN-1:0] ic_rsp_data;

  ifu i_ifu (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .redirect_pc_i   (redirect_pc_i),
    .lookup_pc_o     (lookup_pc),
    .pred_i          (bpu_pred),
    .ic_req_valid_o  (ic_req_valid),
    .ic_req_addr_o   (ic_req_addr),
    .ic_flush_o      (ic_flush),
    .ic_rsp_valid_i  (ic_rsp_valid),
    .ic_rsp_data_i   (ic_rsp_data),
    .ibuffer_valid_o (ibuffer_valid_o),
    .ibuffer_ready_i (ibuffer_ready_i),
    .ibuffer_group_o (ibuffer_group_o)
  );

  bpu i_bpu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (lookup_pc),
    .pred_o      (bpu_pred),
    .update_i    (bpu_update_i)
  );

  icache i_icache (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_valid_i      (ic_req_valid),
    .req_addr_i       (ic_req_addr),
    .flush_i          (ic_flush),
    .rsp_valid_o      (ic_rsp_valid),
    .rsp_data_o       (ic_rsp_data),
    .miss_req_valid_o (miss_req_valid_o),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_req_paddr_o (miss_req_paddr_o),
    .miss_req_index_o (miss_req_index_o),
    .refill_valid_i   (refill_valid_i),
    .refill_ready_o   (refill_ready_o),
    .refill_paddr_i   (refill_paddr_i),
    .refill_data_i    (refill_data_i)
  );

endmodule

/* hw/icache.sv */
// Direct-mapped instruction cache with hit path, miss request and line refill
`timescale 1ns/1ps

module icache (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          req_valid_i,
  input  logic [fe_pkg::PLEN-1:0]                       req_addr_i,
  input  logic                                          flush_i,
  output logic                                          rsp_valid_o,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rsp_data_o,
  output logic                                          miss_req_valid_o,
  input  logic                                          miss_req_ready_i,
  output logic [fe_pkg::PLEN-1:0]                       miss_req_paddr_o,
  output logic [fe_pkg::IC_INDEX_W-1:0]                 miss_req_index_o,
  input  logic                                          refill_valid_i,
  output logic                                          refill_ready_o,
  input  logic [fe_pkg::PLEN-1:0]                       refill_paddr_i,
  input  logic [fe_pkg::LINE_BITS-1:0]                  refill_data_i
);
  import fe_pkg::*;

  logic [IC_SETS-1:0]   valid_q;
  logic [IC_TAG_W-1:0]  tag_q  [IC_SETS];
  logic [LINE_BITS-1:0] line_q [IC_SETS];

  ic_state_e                        state_q;
  logic [PLEN-1:0]                  miss_addr_q;
  logic                             drop_q;
  logic                             pend_q;
  logic [PLEN-1:0]                  pend_addr_q;
  logic                             rsp_valid_q;
  logic [FETCH_WIDTH-1:0][ILEN-1:0] rsp_data_q;

  logic                  lk_valid;
  logic [PLEN-1:0]       lk_addr;
  logic [IC_INDEX_W-1:0] lk_index;
  logic                  lk_hit;
  logic                  busy_req;
  logic                  refill_fire;
  logic [IC_INDEX_W-1:0] refill_index;

  // Address bit 3 picks the half line
  function automatic logic [GROUP_W-1:0] half_sel(input logic [LINE_BITS-1:0] line,
                                                  input logic upper);
    return upper ? line[GROUP_W +: GROUP_W] : line[0 +: GROUP_W];
  endfunction

  // A request that arrives during a refill waits in pend_q
  assign lk_addr      = pend_q ? pend_addr_q : req_addr_i;
  assign lk_valid     = (state_q == READY) && (pend_q || req_valid_i) && !flush_i;
  assign lk_index     = lk_addr[IC_OFFSET_W +: IC_INDEX_W];
  assign lk_hit       = valid_q[lk_index] && (tag_q[lk_index] == lk_addr[PLEN-1 -: IC_TAG_W]);
  assign busy_req     = req_valid_i && (state_q != READY);
  assign refill_fire  = (state_q == REFILL) && refill_valid_i;
  assign refill_index = refill_paddr_i[IC_OFFSET_W +: IC_INDEX_W];

  assign miss_req_valid_o = (state_q == MISS_REQ);
  assign miss_req_paddr_o = {miss_addr_q[PLEN-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}};
  assign miss_req_index_o = miss_addr_q[IC_OFFSET_W +: IC_INDEX_W];
  assign refill_ready_o   = (state_q == REFILL);
  assign rsp_valid_o      = rsp_valid_q;
  assign rsp_data_o       = rsp_data_q;

  // ==========================================================
  // Control
  // ==========================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= READY;
      valid_q     <= '0;
      drop_q      <= 1'b0;
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        READY: begin
          if (lk_valid) begin
            pend_q <= 1'b0;
            if (lk_hit) begin
              rsp_valid_q <= 1'b1;
            end else begin
              state_q <= MISS_REQ;
              drop_q  <= 1'b0;
            end
          end
        end
        MISS_REQ: begin
          if (miss_req_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (refill_valid_i) begin
            state_q                <= READY;
            valid_q[refill_index]  <= 1'b1;
            rsp_valid_q            <= !drop_q && !flush_i;
          end
        end
        default: state_q <= READY;
      endcase

      // Flush kills the response but the line still lands in the array
      if (flush_i) begin
        pend_q <= 1'b0;
        if (state_q != READY) begin
          drop_q <= 1'b1;
        end
      end else if (busy_req) begin
        pend_q <= 1'b1;
      end
    end
  end

  // ==========================================================
  // Array and payload
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (refill_fire) begin
      tag_q[refill_index]  <= refill_paddr_i[PLEN-1 -: IC_TAG_W];
      line_q[refill_index] <= refill_data_i;
      rsp_data_q           <= half_sel(refill_data_i, miss_addr_q[3]);
    end else if (lk_valid) begin
      miss_addr_q <= lk_addr;
      rsp_data_q  <= half_sel(line_q[lk_index], lk_addr[3]);
    end
    if (busy_req) begin
      pend_addr_q <= req_addr_i;
    end
  end

endmodule

/* hw/ifu.sv */
// Fetch unit with PC sequencing, epoch tracking, cache request control and output group
`timescale 1ns/1ps

module ifu (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          flush_i,
  input  logic [fe_pkg::PLEN-1:0]                       redirect_pc_i,
  output logic [fe_pkg::PLEN-1:0]                       lookup_pc_o,
  input  fe_pkg::bpu_pred_t                             pred_i,
  output logic                                          ic_req_valid_o,
  output logic [fe_pkg::PLEN-1:0]                       ic_req_addr_o,
  output logic                                          ic_flush_o,
  input  logic                                          ic_rsp_valid_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] ic_rsp_data_i,
  output logic                                          ibuffer_valid_o,
  input  logic                                          ibuffer_ready_i,
  output fe_pkg::fetch_group_t                          ibuffer_group_o
);
  import fe_pkg::*;

  fetch_state_e       state_q;
  fetch_state_e       state_d;
  logic [PLEN-1:0]    fetch_pc_q;
  logic [EPOCH_W-1:0] epoch_q;
  fetch_group_t       group_q;

  logic [PLEN-1:0]                  group_pc;
  logic [PLEN-1:0]                  next_pc;
  logic [FETCH_WIDTH-1:0]           slot_valid;
  logic [FETCH_WIDTH-1:0][PLEN-1:0] pred_npc;

  // fetch_pc_q keeps bit 2 so a mid-group target marks its entry slot
  assign group_pc = {fetch_pc_q[PLEN-1:3], 3'b000};
  assign next_pc  = pred_i.hit ? pred_i.target : group_pc + PLEN'(4 * FETCH_WIDTH);

  assign lookup_pc_o     = fetch_pc_q;
  assign ic_req_addr_o   = group_pc;
  assign ic_req_valid_o  = (state_q == LOOKUP) && !flush_i;
  assign ic_flush_o      = flush_i;
  assign ibuffer_valid_o = (state_q == HOLD);
  assign ibuffer_group_o = group_q;

  // Slots run from the entry slot through the predicted slot
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slot_valid[s] = (s >= int'(fetch_pc_q[2])) &&
                      (!pred_i.hit || s <= int'(pred_i.slot));
      if (pred_i.hit && int'(pred_i.slot) == s) begin
        pred_npc[s] = pred_i.target;
      end else begin
        pred_npc[s] = group_pc + PLEN'(4 * (s + 1));
      end
    end
  end

  // ==========================================================
  // Fetch FSM
  // ==========================================================
  always_comb begin
    state_d = state_q;
    if (flush_i) begin
      state_d = LOOKUP;
    end else begin
      case (state_q)
        IDLE:     state_d = LOOKUP;
        LOOKUP:   state_d = WAIT_RSP;
        WAIT_RSP: begin
          if (ic_rsp_valid_i) begin
            state_d = HOLD;
          end
        end
        HOLD: begin
          if (ibuffer_ready_i) begin
            state_d = LOOKUP;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= LOOKUP;
      fetch_pc_q <= RESET_PC;
      epoch_q    <= '0;
    end else begin
      state_q <= state_d;
      if (flush_i) begin
        fetch_pc_q <= {redirect_pc_i[PLEN-1:2], 2'b00};
        epoch_q    <= epoch_q + EPOCH_W'(1);
      end else if (state_q == LOOKUP) begin
        fetch_pc_q <= next_pc;
      end
    end
  end

  // ==========================================================
  // Output group register
  // ==========================================================
  // Prediction fields load at issue, words on the cache response
  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP) begin
      group_q.pc         <= group_pc;
      group_q.slot_valid <= slot_valid;
      group_q.pred_npc   <= pred_npc;
      group_q.epoch      <= epoch_q;
    end
    if (state_q == WAIT_RSP && ic_rsp_valid_i) begin
      group_q.instr <= ic_rsp_data_i;
    end
  end

endmodule
